// File: source/csr_pkg.sv
package csr_pkg;

  // Register and address widths
  parameter int csr_data_width = 32;
  parameter int csr_addr_width = 12;

  // Machine trap setup and handling
  parameter logic [csr_addr_width-1:0] csr_mstatus = 12'h300;
  parameter logic [csr_addr_width-1:0] csr_mie     = 12'h304;
  parameter logic [csr_addr_width-1:0] csr_mtvec   = 12'h305;
  parameter logic [csr_addr_width-1:0] csr_mepc    = 12'h341;
  parameter logic [csr_addr_width-1:0] csr_mcause  = 12'h342;
  parameter logic [csr_addr_width-1:0] csr_mip     = 12'h344;

  // Machine counters
  parameter logic [csr_addr_width-1:0] csr_mcycle    = 12'hb00;
  parameter logic [csr_addr_width-1:0] csr_minstret  = 12'hb02;
  parameter logic [csr_addr_width-1:0] csr_mcycleh   = 12'hb80;
  parameter logic [csr_addr_width-1:0] csr_minstreth = 12'hb82;

  // Identity registers, all hardwired to zero
  parameter logic [csr_addr_width-1:0] csr_mvendorid = 12'hf11;
  parameter logic [csr_addr_width-1:0] csr_marchid   = 12'hf12;
  parameter logic [csr_addr_width-1:0] csr_mimpid    = 12'hf13;
  parameter logic [csr_addr_width-1:0] csr_mhartid   = 12'hf14;

  // Field positions
  parameter int mie_bit  = 3;   // mstatus.MIE
  parameter int mpie_bit = 7;   // mstatus.MPIE
  parameter int mpp_lsb  = 11;  // mstatus.MPP, two bits
  parameter int meie_bit = 11;  // mie.MEIE
  parameter int meip_bit = 11;  // mip.MEIP

  parameter logic [csr_data_width-1:0] csr_empty_data = '0;

endpackage

// File: source/trap_pkg.sv
package trap_pkg;

  // Sequencer states
  typedef enum logic [1:0] {
    st_run   = 2'd0,  // Normal execution
    st_sleep = 2'd1,  // Waiting in WFI
    st_enter = 2'd2   // One-cycle trap entry
  } seq_state_t;

  // Machine external interrupt: interrupt bit plus code 11
  parameter logic [31:0] irq_cause = 32'h8000_000b;

endpackage

// File: source/trap_sequencer.sv
`timescale 1ns/1ps

module trap_sequencer
  import trap_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        csr_wait_i,
  input  logic        irq_pending_i,
  input  logic        irq_enabled_i,
  input  logic [31:0] curr_pc_i,
  output logic        stall_o,
  output logic        trap_take_o,
  output logic [31:0] wfi_o
);

  seq_state_t  state;
  seq_state_t  state_nx;
  logic        irq_go;     // Pending and globally enabled
  logic [31:0] resume_pc;  // Value that goes to mepc on entry

  assign irq_go = irq_pending_i & irq_enabled_i;

  always_comb begin
    state_nx = state;
    case (state)
      st_run: begin
        if (irq_go) begin
          state_nx = st_enter;
        end else if (csr_wait_i) begin
          state_nx = st_sleep;
        end
      end
      st_sleep: begin
        // Any pending interrupt wakes, only an enabled one traps
        if (irq_pending_i) begin
          state_nx = irq_enabled_i ? st_enter : st_run;
        end
      end
      st_enter: state_nx = st_run;
      default:  state_nx = st_run;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= st_run;
    end else begin
      state <= state_nx;
    end
  end

  // Interrupt in run saves the current PC, WFI saves the next one
  // Sleep keeps whatever WFI stored
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      resume_pc <= 32'h0;
    end else if (state == st_run) begin
      if (irq_go) begin
        resume_pc <= curr_pc_i;
      end else if (csr_wait_i) begin
        resume_pc <= curr_pc_i + 32'd4;
      end
    end
  end

  assign stall_o     = (state == st_sleep);
  assign trap_take_o = (state == st_enter);  // Exactly one cycle per entry
  assign wfi_o       = resume_pc;

endmodule

// File: source/csr_counters.sv
`timescale 1ns/1ps

module csr_counters
  import csr_pkg::*;
(
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      retire_i,
  input  logic [csr_addr_width-1:0] csr_addr_i,
  input  logic [csr_data_width-1:0] csr_wdata_i,
  input  logic                      csr_write_i,
  output logic [csr_data_width-1:0] mcycle_o,
  output logic [csr_data_width-1:0] mcycleh_o,
  output logic [csr_data_width-1:0] minstret_o,
  output logic [csr_data_width-1:0] minstreth_o
);

  logic [2*csr_data_width-1:0] cycle_q;
  logic [2*csr_data_width-1:0] instret_q;
  logic wr_cycle_lo;
  logic wr_cycle_hi;
  logic wr_instret_lo;
  logic wr_instret_hi;

  assign wr_cycle_lo   = csr_write_i & (csr_addr_i == csr_mcycle);
  assign wr_cycle_hi   = csr_write_i & (csr_addr_i == csr_mcycleh);
  assign wr_instret_lo = csr_write_i & (csr_addr_i == csr_minstret);
  assign wr_instret_hi = csr_write_i & (csr_addr_i == csr_minstreth);

  // Free running, a half write skips that cycle's increment
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cycle_q <= '0;
    end else if (wr_cycle_lo) begin
      cycle_q <= {cycle_q[2*csr_data_width-1:csr_data_width], csr_wdata_i};
    end else if (wr_cycle_hi) begin
      cycle_q <= {csr_wdata_i, cycle_q[csr_data_width-1:0]};
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instret_q <= '0;
    end else if (wr_instret_lo) begin
      instret_q <= {instret_q[2*csr_data_width-1:csr_data_width], csr_wdata_i};
    end else if (wr_instret_hi) begin
      instret_q <= {csr_wdata_i, instret_q[csr_data_width-1:0]};
    end else if (retire_i) begin
      instret_q <= instret_q + 1'b1;  // One per retired instruction
    end
  end

  assign mcycle_o    = cycle_q[csr_data_width-1:0];
  assign mcycleh_o   = cycle_q[2*csr_data_width-1:csr_data_width];
  assign minstret_o  = instret_q[csr_data_width-1:0];
  assign minstreth_o = instret_q[2*csr_data_width-1:csr_data_width];

endmodule

// File: source/csr_regs.sv
`timescale 1ns/1ps

module csr_regs
  import csr_pkg::*;
  import trap_pkg::*;
#(
  parameter logic [31:0] MTVEC_RESET = 32'h0001_0000
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ext_irq_i,
  input  logic [csr_addr_width-1:0] csr_addr_i,
  input  logic [csr_data_width-1:0] csr_wdata_i,
  input  logic                      csr_write_i,
  input  logic                      csr_ret_i,
  input  logic [csr_data_width-1:0] curr_pc_i,
  input  logic                      trap_take_i,
  input  logic [csr_data_width-1:0] wfi_i,
  input  logic [csr_data_width-1:0] mcycle_i,
  input  logic [csr_data_width-1:0] mcycleh_i,
  input  logic [csr_data_width-1:0] minstret_i,
  input  logic [csr_data_width-1:0] minstreth_i,
  output logic                      irq_pending_o,
  output logic                      irq_enabled_o,
  output logic [csr_data_width-1:0] csr_rdata_o,
  output logic [csr_data_width-1:0] trap_target_o,
  output logic [csr_data_width-1:0] epc_o
);

  // Implemented fields only
  logic                      st_mie;
  logic                      st_mpie;
  logic [1:0]                st_mpp;
  logic                      meie;
  logic                      meip;
  logic [csr_data_width-1:0] mtvec;
  logic [csr_data_width-1:0] mepc;
  logic [csr_data_width-1:0] mcause;
  logic [csr_data_width-1:0] mstatus_rd;
  logic [csr_data_width-1:0] mie_rd;
  logic [csr_data_width-1:0] mip_rd;
  logic                      wr_mstatus;
  logic                      wr_mie;
  logic                      wr_mtvec;
  logic                      wr_mepc;

  assign wr_mstatus = csr_write_i & (csr_addr_i == csr_mstatus);
  assign wr_mie     = csr_write_i & (csr_addr_i == csr_mie);
  assign wr_mtvec   = csr_write_i & (csr_addr_i == csr_mtvec);
  assign wr_mepc    = csr_write_i & (csr_addr_i == csr_mepc);

  // mstatus: trap entry, then mret, then software write
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      st_mie  <= 1'b0;
      st_mpie <= 1'b0;
      st_mpp  <= 2'b00;
    end else if (trap_take_i) begin
      st_mpie <= st_mie;
      st_mie  <= 1'b0;
      st_mpp  <= 2'b11;
    end else if (csr_ret_i) begin
      st_mie  <= st_mpie;
      st_mpie <= 1'b1;
      st_mpp  <= 2'b11;
    end else if (wr_mstatus) begin
      st_mie  <= csr_wdata_i[mie_bit];
      st_mpie <= csr_wdata_i[mpie_bit];
      st_mpp  <= csr_wdata_i[mpp_lsb+:2];
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      meie <= 1'b0;
    end else if (wr_mie) begin
      meie <= csr_wdata_i[meie_bit];
    end
  end

  // Pending bit follows the line one edge later
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      meip <= 1'b0;
    end else begin
      meip <= ext_irq_i;
    end
  end

  // Direct mode only, mode bits keep their reset value
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mtvec <= MTVEC_RESET;
    end else if (wr_mtvec) begin
      mtvec[csr_data_width-1:2] <= csr_wdata_i[csr_data_width-1:2];
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mepc   <= csr_empty_data;
      mcause <= csr_empty_data;
    end else if (trap_take_i) begin
      mepc   <= wfi_i;  // Resume PC saved by the sequencer
      mcause <= irq_cause;
    end else if (wr_mepc) begin
      mepc[csr_data_width-1:2] <= csr_wdata_i[csr_data_width-1:2];
    end
  end

  always_comb begin
    mstatus_rd              = csr_empty_data;
    mstatus_rd[mie_bit]     = st_mie;
    mstatus_rd[mpie_bit]    = st_mpie;
    mstatus_rd[mpp_lsb+:2]  = st_mpp;
    mie_rd                  = csr_empty_data;
    mie_rd[meie_bit]        = meie;
    mip_rd                  = csr_empty_data;
    mip_rd[meip_bit]        = meip;
  end

  always_comb begin
    case (csr_addr_i)
      csr_mstatus:   csr_rdata_o = mstatus_rd;
      csr_mie:       csr_rdata_o = mie_rd;
      csr_mtvec:     csr_rdata_o = mtvec;
      csr_mepc:      csr_rdata_o = mepc;
      csr_mcause:    csr_rdata_o = mcause;
      csr_mip:       csr_rdata_o = mip_rd;
      csr_mcycle:    csr_rdata_o = mcycle_i;
      csr_mcycleh:   csr_rdata_o = mcycleh_i;
      csr_minstret:  csr_rdata_o = minstret_i;
      csr_minstreth: csr_rdata_o = minstreth_i;
      csr_mvendorid: csr_rdata_o = csr_empty_data;
      csr_marchid:   csr_rdata_o = csr_empty_data;
      csr_mimpid:    csr_rdata_o = csr_empty_data;
      csr_mhartid:   csr_rdata_o = csr_empty_data;
      default:       csr_rdata_o = csr_empty_data;
    endcase
  end

  assign irq_pending_o = meip & meie;
  assign irq_enabled_o = st_mie;
  assign trap_target_o = mtvec;
  assign epc_o         = mepc;

endmodule

// File: source/csr_unit.sv
`timescale 1ns/1ps

module csr_unit
  import csr_pkg::*;
#(
  parameter logic [31:0] MTVEC_RESET = 32'h0001_0000
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic [csr_addr_width-1:0] csr_addr_i,
  input  logic [csr_data_width-1:0] csr_wdata_i,
  input  logic                      csr_write_i,
  input  logic                      csr_wait_i,
  input  logic                      csr_ret_i,
  input  logic                      retire_i,
  input  logic [csr_data_width-1:0] curr_pc_i,
  input  logic                      ext_irq_i,
  output logic [csr_data_width-1:0] csr_rdata_o,
  output logic                      stall_o,
  output logic                      trap_o,
  output logic [csr_data_width-1:0] trap_target_o,
  output logic [csr_data_width-1:0] epc_o
);

  logic                      irq_pending;
  logic                      irq_enabled;
  logic                      trap_take;
  logic [csr_data_width-1:0] wfi_pc;
  logic [csr_data_width-1:0] mcycle;
  logic [csr_data_width-1:0] mcycleh;
  logic [csr_data_width-1:0] minstret;
  logic [csr_data_width-1:0] minstreth;

  trap_sequencer u_seq (
    .clk           (clk),
    .rstn          (rstn),
    .csr_wait_i    (csr_wait_i),
    .irq_pending_i (irq_pending),
    .irq_enabled_i (irq_enabled),
    .curr_pc_i     (curr_pc_i),
    .stall_o       (stall_o),
    .trap_take_o   (trap_take),
    .wfi_o         (wfi_pc)
  );

  csr_counters u_cnt (
    .clk         (clk),
    .rstn        (rstn),
    .retire_i    (retire_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_write_i (csr_write_i),
    .mcycle_o    (mcycle),
    .mcycleh_o   (mcycleh),
    .minstret_o  (minstret),
    .minstreth_o (minstreth)
  );

  csr_regs #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_regs (
    .clk           (clk),
    .rstn          (rstn),
    .ext_irq_i     (ext_irq_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_write_i   (csr_write_i),
    .csr_ret_i     (csr_ret_i),
    .curr_pc_i     (curr_pc_i),
    .trap_take_i   (trap_take),
    .wfi_i         (wfi_pc),
    .mcycle_i      (mcycle),
    .mcycleh_i     (mcycleh),
    .minstret_i    (minstret),
    .minstreth_i   (minstreth),
    .irq_pending_o (irq_pending),
    .irq_enabled_o (irq_enabled),
    .csr_rdata_o   (csr_rdata_o),
    .trap_target_o (trap_target_o),
    .epc_o         (epc_o)
  );

  assign trap_o = trap_take;  // Trap entry pulse to the core

endmodule

// File: bench/csr_unit_assertions.sv
`timescale 1ns/1ps

module csr_unit_assertions
  import csr_pkg::*;
#(
  parameter logic [31:0] MTVEC_RESET = 32'h0001_0000
) (
  input logic        clk,
  input logic        rstn,
  input logic [11:0] csr_addr_i,
  input logic [31:0] csr_wdata_i,
  input logic        csr_write_i,
  input logic        csr_wait_i,
  input logic        csr_ret_i,
  input logic        retire_i,
  input logic [31:0] curr_pc_i,
  input logic        ext_irq_i,
  input logic [31:0] csr_rdata_i,
  input logic        stall_i,
  input logic        trap_i,
  input logic [31:0] trap_target_i,
  input logic [31:0] epc_i
);

  int          fail_count = 0;  // Read by the testbench
  logic [63:0] sh_cycle;
  logic [63:0] sh_instret;
  logic [31:0] sh_mtvec;
  logic        sh_mie;
  logic        sh_mpie;
  logic [31:0] prev_pc;     // PC seen in the decision cycle
  logic        prev_stall;
  logic [31:0] wfi_pc;      // Resume point after WFI
  logic [31:0] exp_epc;

  assign exp_epc = prev_stall ? wfi_pc : prev_pc;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sh_cycle   <= '0;
      sh_instret <= '0;
      sh_mtvec   <= MTVEC_RESET;
      sh_mie     <= 1'b0;
      sh_mpie    <= 1'b0;
      prev_pc    <= '0;
      prev_stall <= 1'b0;
      wfi_pc     <= '0;
    end else begin
      prev_pc    <= curr_pc_i;
      prev_stall <= stall_i;
      if (csr_wait_i && !stall_i) wfi_pc <= curr_pc_i + 32'd4;
      if (csr_write_i && csr_addr_i == csr_mcycle) sh_cycle[31:0] <= csr_wdata_i;
      else if (csr_write_i && csr_addr_i == csr_mcycleh) sh_cycle[63:32] <= csr_wdata_i;
      else sh_cycle <= sh_cycle + 64'd1;
      if (csr_write_i && csr_addr_i == csr_minstret) sh_instret[31:0] <= csr_wdata_i;
      else if (csr_write_i && csr_addr_i == csr_minstreth) sh_instret[63:32] <= csr_wdata_i;
      else if (retire_i) sh_instret <= sh_instret + 64'd1;
      if (csr_write_i && csr_addr_i == csr_mtvec) sh_mtvec[31:2] <= csr_wdata_i[31:2];
      if (trap_i) begin  // Entry saves MIE into MPIE
        sh_mpie <= sh_mie;
        sh_mie  <= 1'b0;
      end else if (csr_ret_i) begin
        sh_mie  <= sh_mpie;
        sh_mpie <= 1'b1;
      end else if (csr_write_i && csr_addr_i == csr_mstatus) begin
        sh_mie  <= csr_wdata_i[mie_bit];
        sh_mpie <= csr_wdata_i[mpie_bit];
      end
    end
  end

  a_cycle: assert property (@(posedge clk) disable iff (!rstn)
    csr_addr_i == csr_mcycle |-> csr_rdata_i == sh_cycle[31:0])
    else begin
      $error("mcycle differs from shadow count");
      fail_count++;
    end

  a_instret: assert property (@(posedge clk) disable iff (!rstn)
    csr_addr_i == csr_minstret |-> csr_rdata_i == sh_instret[31:0])
    else begin
      $error("minstret differs from retire count");
      fail_count++;
    end

  a_target: assert property (@(posedge clk) disable iff (!rstn)
    trap_target_i == sh_mtvec)
    else begin
      $error("trap_target_o differs from mtvec");
      fail_count++;
    end

  a_status: assert property (@(posedge clk) disable iff (!rstn)
    csr_addr_i == csr_mstatus |->
      csr_rdata_i[mie_bit] == sh_mie && csr_rdata_i[mpie_bit] == sh_mpie)
    else begin
      $error("mstatus MIE or MPIE wrong");
      fail_count++;
    end

  a_one_pulse: assert property (@(posedge clk) disable iff (!rstn)
    trap_i |=> !trap_i)
    else begin
      $error("trap_o longer than one cycle");
      fail_count++;
    end

  a_trap_enabled: assert property (@(posedge clk) disable iff (!rstn)
    trap_i |-> sh_mie)
    else begin
      $error("trap_o with MIE clear");
      fail_count++;
    end

  a_trap_epc: assert property (@(posedge clk) disable iff (!rstn)
    trap_i |=> epc_i == $past(exp_epc))
    else begin
      $error("mepc after trap entry wrong");
      fail_count++;
    end

  a_wake: assert property (@(posedge clk) disable iff (!rstn)
    $fell(stall_i) |-> $past(ext_irq_i, 2))
    else begin
      $error("stall_o dropped without interrupt");
      fail_count++;
    end

endmodule

// File: bench/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb
  import csr_pkg::*;
  import trap_pkg::*;
();

  localparam logic [31:0] MTVEC_RESET = 32'h0001_0000;
  localparam int          max_cycles  = 2000;  // Tests need about 700
  localparam int          wait_limit  = 64;

  logic        clk = 1'b0;
  logic        rstn;
  logic [11:0] csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic        csr_write_i;
  logic        csr_wait_i;
  logic        csr_ret_i;
  logic        retire_i;
  logic [31:0] curr_pc_i;
  logic        ext_irq_i;
  logic [31:0] csr_rdata_o;
  logic        stall_o;
  logic        trap_o;
  logic [31:0] trap_target_o;
  logic [31:0] epc_o;
  logic [31:0] seed = 32'hbca9_4b32;
  int          errors = 0;
  int          cycles = 0;

  csr_unit #(.MTVEC_RESET(MTVEC_RESET)) uut (.*);

  bind csr_unit csr_unit_assertions #(.MTVEC_RESET(MTVEC_RESET)) u_asrt (
    .clk(clk), .rstn(rstn), .csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata_i),
    .csr_write_i(csr_write_i), .csr_wait_i(csr_wait_i), .csr_ret_i(csr_ret_i),
    .retire_i(retire_i), .curr_pc_i(curr_pc_i), .ext_irq_i(ext_irq_i),
    .csr_rdata_i(csr_rdata_o), .stall_i(stall_o), .trap_i(trap_o),
    .trap_target_i(trap_target_o), .epc_i(epc_o)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic step(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
    csr_addr_i  = addr;
    csr_wdata_i = data;
    csr_write_i = 1'b1;
    step(1);
    csr_write_i = 1'b0;
  endtask

  // Read is combinational, sampled in the low phase, one cycle per read
  task automatic check_read(input logic [11:0] addr, input logic [31:0] exp, input string name);
    csr_addr_i = addr;
    #1;
    check_value(name, csr_rdata_o, exp);
    if (addr == csr_mepc) check_value("epc_o", epc_o, exp);
    if (addr == csr_mtvec) check_value("trap_target_o", trap_target_o, exp);
    step(1);
  endtask

  task automatic wait_trap();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < wait_limit && !seen; i++) begin
      step(1);
      seen = trap_o;
    end
    if (!seen) begin
      $display("trap_o did not fire within %0d cycles", wait_limit);
      errors++;
    end
  endtask

  task automatic expect_no_trap(input int n);
    for (int i = 0; i < n; i++) begin
      step(1);
      if (trap_o) begin
        $display("Unexpected trap_o pulse at %0t", $time);
        errors++;
      end
    end
  endtask

  task automatic pulse_wfi(input logic [31:0] pc);
    curr_pc_i  = pc;
    csr_wait_i = 1'b1;
    step(1);
    csr_wait_i = 1'b0;
  endtask

  initial begin
    logic [31:0] d;
    logic [31:0] a;
    logic [31:0] pc;
    int          count;
    rstn        = 1'b0;
    csr_addr_i  = '0;
    csr_wdata_i = '0;
    csr_write_i = 1'b0;
    csr_wait_i  = 1'b0;
    csr_ret_i   = 1'b0;
    retire_i    = 1'b0;
    curr_pc_i   = '0;
    ext_irq_i   = 1'b0;
    repeat (5) @(negedge clk);
    rstn = 1'b1;
    step(1);

    // Reset values, identity and unknown addresses
    check_read(csr_mstatus, 32'h0, "mstatus");
    check_read(csr_mie, 32'h0, "mie");
    check_read(csr_mip, 32'h0, "mip");
    check_read(csr_mtvec, MTVEC_RESET, "mtvec");
    check_read(csr_mepc, 32'h0, "mepc");
    check_read(csr_mcause, 32'h0, "mcause");
    check_read(csr_minstret, 32'h0, "minstret");
    check_read(csr_mcycleh, 32'h0, "mcycleh");
    check_read(csr_mvendorid, 32'h0, "mvendorid");
    check_read(csr_marchid, 32'h0, "marchid");
    check_read(csr_mimpid, 32'h0, "mimpid");
    check_read(csr_mhartid, 32'h0, "mhartid");
    check_read(12'h7c0, 32'h0, "unknown csr");

    repeat (4) begin
      d = lcg_next();
      write_csr(csr_mstatus, d);
      check_read(csr_mstatus, d & 32'h0000_1888, "mstatus");
      write_csr(csr_mie, d);
      check_read(csr_mie, d & 32'h0000_0800, "mie");
      write_csr(csr_mtvec, d);
      check_read(csr_mtvec, {d[31:2], MTVEC_RESET[1:0]}, "mtvec");
      write_csr(csr_mepc, ~d);
      check_read(csr_mepc, ~d & 32'hffff_fffc, "mepc");
    end
    write_csr(csr_mstatus, 32'h0);
    write_csr(csr_mie, 32'h0);

    // Counters
    repeat (3) begin
      csr_addr_i = csr_mcycle;
      #1 a = csr_rdata_o;
      step(1);
      check_read(csr_mcycle, a + 32'd1, "mcycle");
      d = lcg_next() & 32'h7fff_ffff;
      write_csr(csr_mcycle, d);
      check_read(csr_mcycle, d, "mcycle");
      step(2);  // One increment already fell inside the read
      check_read(csr_mcycle, d + 32'd3, "mcycle");
      write_csr(csr_mcycleh, ~d);
      check_read(csr_mcycleh, ~d, "mcycleh");
      write_csr(csr_minstret, 32'h0);
      count = 0;
      repeat (40) begin
        d = lcg_next();
        retire_i = d[31];
        if (retire_i) count++;
        step(1);
      end
      retire_i = 1'b0;
      check_read(csr_minstret, count, "minstret");
    end

    // Interrupt entry
    repeat (3) begin
      write_csr(csr_mie, 32'h0000_0800);
      write_csr(csr_mstatus, 32'h0000_0008);
      pc = lcg_next() & 32'hffff_fffc;
      curr_pc_i = pc;
      step(lcg_next() % 8);
      ext_irq_i = 1'b1;
      wait_trap();
      ext_irq_i = 1'b0;
      expect_no_trap(4);
      check_read(csr_mepc, pc, "mepc");
      check_read(csr_mcause, irq_cause, "mcause");
      check_read(csr_mstatus, 32'h0000_1880, "mstatus");
      write_csr(csr_mstatus, 32'h0);
      ext_irq_i = 1'b1;
      expect_no_trap(10);
      ext_irq_i = 1'b0;
      step(2);
    end

    // WFI with interrupts enabled, then disabled
    repeat (3) begin
      write_csr(csr_mstatus, 32'h0000_0008);
      pc = lcg_next() & 32'hffff_fffc;
      pulse_wfi(pc);
      repeat (lcg_next() % 10 + 2) begin
        check_value("stall_o", stall_o, 1'b1);
        step(1);
      end
      ext_irq_i = 1'b1;
      wait_trap();
      ext_irq_i = 1'b0;
      step(2);
      check_read(csr_mepc, pc + 32'd4, "mepc");
      write_csr(csr_mstatus, 32'h0);
      pulse_wfi(pc);
      step(lcg_next() % 10 + 2);
      check_value("stall_o", stall_o, 1'b1);
      ext_irq_i = 1'b1;
      for (int i = 0; i < wait_limit && stall_o; i++) step(1);
      if (stall_o) begin
        $display("stall_o did not drop after interrupt wake");
        errors++;
      end
      ext_irq_i = 1'b0;
      expect_no_trap(5);
    end

    // Return from trap
    repeat (2) begin
      write_csr(csr_mstatus, 32'h0000_0080);
      csr_ret_i = 1'b1;
      step(1);
      csr_ret_i = 1'b0;
      check_read(csr_mstatus, 32'h0000_1888, "mstatus");
      write_csr(csr_mstatus, 32'h0000_0008);
      csr_ret_i = 1'b1;
      step(1);
      csr_ret_i = 1'b0;
      check_read(csr_mstatus, 32'h0000_1880, "mstatus");
    end
    step(2);

    $display("Errors: %0d read-back, %0d assertion", errors, uut.u_asrt.fail_count);
    if (errors == 0 && uut.u_asrt.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: csr_unit.f
source/csr_pkg.sv
source/trap_pkg.sv
source/trap_sequencer.sv
source/csr_counters.sv
source/csr_regs.sv
source/csr_unit.sv
bench/csr_unit_assertions.sv
bench/csr_unit_tb.sv

// File: Makefile
# Verilator build and run for the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
RTL_TOP   ?= csr_unit
FLIST     ?= csr_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) \
		source/csr_pkg.sv source/trap_pkg.sv source/trap_sequencer.sv \
		source/csr_counters.sv source/csr_regs.sv source/csr_unit.sv

clean:
	rm -rf $(OBJ_DIR)
